//--- source/fabric_consts.svh
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// bus width
`define DATA_WIDTH 32

// region select lives in the top address nibble
`define SLOT_MSB 31
`define SLOT_LSB 28
`define RAM_SLOT 4'h2
`define GPIO_SLOT 4'h4
`define TIMER_SLOT 4'h5

// data RAM depth in words, indexed by HADDR[9:2]
`define RAM_WORDS 256
`define RAM_INDEX_BITS 8

// peripheral register word offset field
`define REG_OFFSET_MSB 3
`define REG_OFFSET_LSB 2

`endif

//--- source/fabricPkg.sv
package fabricPkg;

    // AHB-Lite transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htransT;

    // transfer size, only the sizes a 32-bit bus can carry
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsizeT;

    // data-phase owner inside the splitter
    typedef enum logic [1:0] {
        SLOT_RAM   = 2'd0,
        SLOT_GPIO  = 2'd1,
        SLOT_TIMER = 2'd2,
        SLOT_NONE  = 2'd3
    } slotT;

    // timer register word offsets
    typedef enum logic [1:0] {
        TMR_LOAD   = 2'd0,
        TMR_CTRL   = 2'd1,
        TMR_COUNT  = 2'd2,
        TMR_STATUS = 2'd3
    } timerRegT;

    // gpio register word offsets, offset 3 is unused
    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_OE  = 2'd1,
        GPIO_IN  = 2'd2
    } gpioRegT;

endpackage

//--- source/ahblSplitter.sv
`include "fabric_consts.svh"

module ahblSplitter import fabricPkg::*; (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic [31:0]            HADDR,
    input  htransT                 HTRANS,
    output logic                   ramSel,
    output logic                   gpioSel,
    output logic                   timerSel,
    input  logic [`DATA_WIDTH-1:0] ramRdata,
    input  logic [`DATA_WIDTH-1:0] gpioRdata,
    input  logic [`DATA_WIDTH-1:0] timerRdata,
    input  logic                   ramReady,
    input  logic                   gpioReady,
    input  logic                   timerReady,
    output logic [`DATA_WIDTH-1:0] HRDATA,
    output logic                   HREADY
);

    slotT addrSlot;
    slotT dataSlot;
    logic transfer;

    assign transfer = (HTRANS == NONSEQ) || (HTRANS == SEQ);

    // region decode on the address phase
    always_comb begin
        case (HADDR[`SLOT_MSB:`SLOT_LSB])
            `RAM_SLOT:   addrSlot = SLOT_RAM;
            `GPIO_SLOT:  addrSlot = SLOT_GPIO;
            `TIMER_SLOT: addrSlot = SLOT_TIMER;
            default:     addrSlot = SLOT_NONE;
        endcase
    end

    assign ramSel   = (addrSlot == SLOT_RAM);
    assign gpioSel  = (addrSlot == SLOT_GPIO);
    assign timerSel = (addrSlot == SLOT_TIMER);

    // slot follows the bus only when the previous data phase completes
    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataSlot <= SLOT_NONE;
        end else if (HREADY) begin
            dataSlot <= transfer ? addrSlot : SLOT_NONE;
        end
    end

    // data-phase return path
    always_comb begin
        case (dataSlot)
            SLOT_RAM: begin
                HRDATA = ramRdata;
                HREADY = ramReady;
            end
            SLOT_GPIO: begin
                HRDATA = gpioRdata;
                HREADY = gpioReady;
            end
            SLOT_TIMER: begin
                HRDATA = timerRdata;
                HREADY = timerReady;
            end
            default: begin
                // unmapped or idle, complete with zero
                HRDATA = '0;
                HREADY = 1'b1;
            end
        endcase
    end

endmodule

//--- source/ahblRam.sv
`include "fabric_consts.svh"

module ahblRam import fabricPkg::*; (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic                   hsel,
    input  logic                   HREADY,
    input  logic [31:0]            HADDR,
    input  htransT                 HTRANS,
    input  hsizeT                  HSIZE,
    input  logic                   HWRITE,
    input  logic [`DATA_WIDTH-1:0] HWDATA,
    output logic                   readyOut,
    output logic [`DATA_WIDTH-1:0] rdata
);

    logic [`DATA_WIDTH-1:0]    mem [`RAM_WORDS];
    logic [`RAM_INDEX_BITS-1:0] wordIndex;
    logic [1:0]                laneReg;
    hsizeT                     sizeReg;
    logic                      writePending;
    logic [`DATA_WIDTH/8-1:0]  laneMask;
    logic                      accept;

    assign accept = hsel && HREADY && ((HTRANS == NONSEQ) || (HTRANS == SEQ));

    always_ff @(posedge HCLK) begin
        if (reset) begin
            writePending <= 1'b0;
        end else if (HREADY) begin
            writePending <= accept && HWRITE;
        end
    end

    // address phase capture
    always_ff @(posedge HCLK) begin
        if (accept) begin
            wordIndex <= HADDR[`RAM_INDEX_BITS+1:2];
            laneReg   <= HADDR[1:0];
            sizeReg   <= HSIZE;
        end
    end

    // byte lanes touched by the pending write
    always_comb begin
        case (sizeReg)
            BYTE:    laneMask = 4'b0001 << laneReg;
            HALF:    laneMask = laneReg[1] ? 4'b1100 : 4'b0011;
            default: laneMask = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (writePending && HREADY) begin
            for (int lane = 0; lane < `DATA_WIDTH / 8; lane++) begin
                if (laneMask[lane]) begin
                    mem[wordIndex][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
                end
            end
        end
    end

    assign rdata    = mem[wordIndex];
    assign readyOut = 1'b1;

endmodule

//--- source/ahblGpio.sv
`include "fabric_consts.svh"

module ahblGpio import fabricPkg::*; (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic                   hsel,
    input  logic                   HREADY,
    input  logic [31:0]            HADDR,
    input  htransT                 HTRANS,
    input  logic                   HWRITE,
    input  logic [`DATA_WIDTH-1:0] HWDATA,
    output logic                   readyOut,
    output logic [`DATA_WIDTH-1:0] rdata,
    input  logic [31:0]            gpioIn,
    output logic [31:0]            gpioOut,
    output logic [31:0]            gpioOe
);

    gpioRegT     regSel;
    logic        writePending;
    logic        accept;
    logic [31:0] inMeta;
    logic [31:0] inSync;

    assign accept = hsel && HREADY && ((HTRANS == NONSEQ) || (HTRANS == SEQ));

    always_ff @(posedge HCLK) begin
        if (reset) begin
            writePending <= 1'b0;
        end else if (HREADY) begin
            writePending <= accept && HWRITE;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            regSel <= gpioRegT'(HADDR[`REG_OFFSET_MSB:`REG_OFFSET_LSB]);
        end
    end

    // output registers, GPIO_IN is read only
    always_ff @(posedge HCLK) begin
        if (reset) begin
            gpioOut <= '0;
            gpioOe  <= '0;
        end else if (writePending && HREADY) begin
            case (regSel)
                GPIO_OUT: gpioOut <= HWDATA;
                GPIO_OE:  gpioOe  <= HWDATA;
                default:  ;
            endcase
        end
    end

    // two-stage input synchronizer
    always_ff @(posedge HCLK) begin
        inMeta <= gpioIn;
        inSync <= inMeta;
    end

    always_comb begin
        case (regSel)
            GPIO_OUT: rdata = gpioOut;
            GPIO_OE:  rdata = gpioOe;
            GPIO_IN:  rdata = inSync;
            default:  rdata = '0;
        endcase
    end

    assign readyOut = 1'b1;

endmodule

//--- source/ahblTimer.sv
`include "fabric_consts.svh"

module ahblTimer import fabricPkg::*; (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic                   hsel,
    input  logic                   HREADY,
    input  logic [31:0]            HADDR,
    input  htransT                 HTRANS,
    input  logic                   HWRITE,
    input  logic [`DATA_WIDTH-1:0] HWDATA,
    output logic                   readyOut,
    output logic [`DATA_WIDTH-1:0] rdata,
    output logic                   timerFlag
);

    timerRegT               regSel;
    logic                   writePending;
    logic                   accept;
    logic                   busWrite;
    logic                   enable;
    logic [`DATA_WIDTH-1:0] loadReg;
    logic [`DATA_WIDTH-1:0] countReg;

    assign accept   = hsel && HREADY && ((HTRANS == NONSEQ) || (HTRANS == SEQ));
    assign busWrite = writePending && HREADY;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            writePending <= 1'b0;
        end else if (HREADY) begin
            writePending <= accept && HWRITE;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            regSel <= timerRegT'(HADDR[`REG_OFFSET_MSB:`REG_OFFSET_LSB]);
        end
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            enable    <= 1'b0;
            timerFlag <= 1'b0;
            loadReg   <= '0;
            countReg  <= '0;
        end else begin
            if (busWrite && (regSel == TMR_CTRL)) begin
                enable <= HWDATA[0];
            end
            if (busWrite && (regSel == TMR_STATUS)) begin
                timerFlag <= 1'b0;
            end
            // a LOAD write restarts the count
            if (busWrite && (regSel == TMR_LOAD)) begin
                loadReg  <= HWDATA;
                countReg <= HWDATA;
            end else if (enable) begin
                if (countReg == '0) begin
                    countReg  <= loadReg;
                    // expiry wins over a clear in the same cycle
                    timerFlag <= 1'b1;
                end else begin
                    countReg <= countReg - 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (regSel)
            TMR_LOAD:  rdata = loadReg;
            TMR_CTRL:  rdata = {{(`DATA_WIDTH-1){1'b0}}, enable};
            TMR_COUNT: rdata = countReg;
            default:   rdata = {{(`DATA_WIDTH-1){1'b0}}, timerFlag};
        endcase
    end

    assign readyOut = 1'b1;

endmodule

//--- source/peripheralFabric.sv
`include "fabric_consts.svh"

module peripheralFabric import fabricPkg::*; (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic [31:0]            HADDR,
    input  htransT                 HTRANS,
    input  hsizeT                  HSIZE,
    input  logic                   HWRITE,
    input  logic [`DATA_WIDTH-1:0] HWDATA,
    output logic [`DATA_WIDTH-1:0] HRDATA,
    output logic                   HREADY,
    input  logic [31:0]            gpioIn,
    output logic [31:0]            gpioOut,
    output logic [31:0]            gpioOe,
    output logic                   timerFlag
);

    logic                   ramSel;
    logic                   gpioSel;
    logic                   timerSel;
    logic [`DATA_WIDTH-1:0] ramRdata;
    logic [`DATA_WIDTH-1:0] gpioRdata;
    logic [`DATA_WIDTH-1:0] timerRdata;
    logic                   ramReady;
    logic                   gpioReady;
    logic                   timerReady;

    // flat decode: RAM at 0x2, GPIO at 0x4, timer at 0x5
    ahblSplitter splitter_i (
        .HCLK(HCLK),
        .reset(reset),
        .HADDR(HADDR),
        .HTRANS(HTRANS),
        .ramSel(ramSel),
        .gpioSel(gpioSel),
        .timerSel(timerSel),
        .ramRdata(ramRdata),
        .gpioRdata(gpioRdata),
        .timerRdata(timerRdata),
        .ramReady(ramReady),
        .gpioReady(gpioReady),
        .timerReady(timerReady),
        .HRDATA(HRDATA),
        .HREADY(HREADY)
    );

    ahblRam ram_i (
        .HCLK(HCLK),
        .reset(reset),
        .hsel(ramSel),
        .HREADY(HREADY),
        .HADDR(HADDR),
        .HTRANS(HTRANS),
        .HSIZE(HSIZE),
        .HWRITE(HWRITE),
        .HWDATA(HWDATA),
        .readyOut(ramReady),
        .rdata(ramRdata)
    );

    ahblGpio gpio_i (
        .HCLK(HCLK),
        .reset(reset),
        .hsel(gpioSel),
        .HREADY(HREADY),
        .HADDR(HADDR),
        .HTRANS(HTRANS),
        .HWRITE(HWRITE),
        .HWDATA(HWDATA),
        .readyOut(gpioReady),
        .rdata(gpioRdata),
        .gpioIn(gpioIn),
        .gpioOut(gpioOut),
        .gpioOe(gpioOe)
    );

    ahblTimer timer_i (
        .HCLK(HCLK),
        .reset(reset),
        .hsel(timerSel),
        .HREADY(HREADY),
        .HADDR(HADDR),
        .HTRANS(HTRANS),
        .HWRITE(HWRITE),
        .HWDATA(HWDATA),
        .readyOut(timerReady),
        .rdata(timerRdata),
        .timerFlag(timerFlag)
    );

endmodule

//--- verification/tbClock.sv
module tbClock (
    output logic clk
);

    // period of 8, first rising edge at 4
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

//--- verification/peripheralFabricTb.sv
`include "fabric_consts.svh"

module peripheralFabricTb import fabricPkg::*; ();

    localparam int readyTimeout = 50;
    localparam int flagTimeout  = 40;

    logic                   HCLK;
    logic                   reset;
    logic [31:0]            HADDR;
    htransT                 HTRANS;
    hsizeT                  HSIZE;
    logic                   HWRITE;
    logic [`DATA_WIDTH-1:0] HWDATA;
    logic [`DATA_WIDTH-1:0] HRDATA;
    logic                   HREADY;
    logic [31:0]            gpioIn;
    logic [31:0]            gpioOut;
    logic [31:0]            gpioOe;
    logic                   timerFlag;

    // expected state of the slaves
    logic [31:0] ramImage [`RAM_WORDS];
    logic [31:0] gpioOutModel;
    logic [31:0] gpioOeModel;
    logic [31:0] gpioInModel;

    integer seed;
    int     errors   = 0;
    int     checks   = 0;
    int     timeouts = 0;
    int     cycles   = 0;

    // read checks follow the bus pipeline
    logic        addrCheck = 1'b0;
    logic        dataCheck = 1'b0;
    logic [31:0] addrExpect;
    logic [31:0] dataExpect;
    string       addrName;
    string       dataName;

    tbClock clock_i (
        .clk(HCLK)
    );

    peripheralFabric dut_i (
        .HCLK(HCLK),
        .reset(reset),
        .HADDR(HADDR),
        .HTRANS(HTRANS),
        .HSIZE(HSIZE),
        .HWRITE(HWRITE),
        .HWDATA(HWDATA),
        .HRDATA(HRDATA),
        .HREADY(HREADY),
        .gpioIn(gpioIn),
        .gpioOut(gpioOut),
        .gpioOe(gpioOe),
        .timerFlag(timerFlag)
    );

    function automatic logic [31:0] regAddr(logic [3:0] slot, logic [1:0] offset);
        return {slot, 24'h0, offset, 2'b00};
    endfunction

    // lanes picked by size and low address bits
    function automatic logic [31:0] mergeLanes(logic [31:0] oldWord, logic [31:0] newWord,
                                               logic [1:0] offset, hsizeT size);
        logic [31:0] merged;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            if ((size == WORD) || ((size == HALF) && ((b / 2) == offset[1])) ||
                ((size == BYTE) && (b == offset))) begin
                merged[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [31:0] expectedRead(logic [31:0] addr);
        case (addr[31:28])
            `RAM_SLOT: return ramImage[addr[27:2] % `RAM_WORDS];
            `GPIO_SLOT: begin
                case (addr[3:2])
                    GPIO_OUT: return gpioOutModel;
                    GPIO_OE:  return gpioOeModel;
                    GPIO_IN:  return gpioInModel;
                    default:  return 32'h0;
                endcase
            end
            default: return 32'h0;
        endcase
    endfunction

    task automatic modelWrite(input logic [31:0] addr, input hsizeT size,
                              input logic [31:0] data);
        int index;
        index = addr[27:2] % `RAM_WORDS;
        if (addr[31:28] == `RAM_SLOT) begin
            ramImage[index] = mergeLanes(ramImage[index], data, addr[1:0], size);
        end else if (addr[31:28] == `GPIO_SLOT) begin
            if (addr[3:2] == GPIO_OUT) begin
                gpioOutModel = data;
            end else if (addr[3:2] == GPIO_OE) begin
                gpioOeModel = data;
            end
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one address phase with its write data in the next cycle
    task automatic drivePhase(input logic [31:0] addr, input htransT trans, input hsizeT size,
                              input logic write, input logic [31:0] wdata,
                              input logic check, input string name);
        int waited;
        HADDR  = addr;
        HTRANS = trans;
        HSIZE  = size;
        HWRITE = write;
        if (write && (trans == NONSEQ)) begin
            modelWrite(addr, size, wdata);
        end
        addrCheck  = check;
        addrExpect = expectedRead(addr);
        addrName   = name;
        waited = 0;
        do begin
            @(posedge HCLK);
            waited++;
        end while (!HREADY && (waited < readyTimeout));
        if (!HREADY) begin
            timeouts++;
            $display("timeout: HREADY stayed low for %0d cycles", waited);
        end
        #1;
        HWDATA    = write ? wdata : '0;
        HTRANS    = IDLE;
        HWRITE    = 1'b0;
        addrCheck = 1'b0;
    endtask

    task automatic writeBus(input logic [31:0] addr, input hsizeT size, input logic [31:0] data);
        drivePhase(addr, NONSEQ, size, 1'b1, data, 1'b0, "");
    endtask

    task automatic readCheck(input logic [31:0] addr, input string name);
        drivePhase(addr, NONSEQ, WORD, 1'b0, '0, 1'b1, name);
    endtask

    task automatic idleCycle();
        drivePhase('0, IDLE, WORD, 1'b0, '0, 1'b0, "");
    endtask

    task automatic readValue(input logic [31:0] addr, output logic [31:0] data);
        int waited;
        drivePhase(addr, NONSEQ, WORD, 1'b0, '0, 1'b0, "");
        waited = 0;
        do begin
            @(negedge HCLK);
            waited++;
        end while (!HREADY && (waited < readyTimeout));
        if (!HREADY) begin
            timeouts++;
            $display("timeout: read data phase never completed");
        end
        data = HRDATA;
        @(posedge HCLK);
        #1;
    endtask

    // advance the check on every completed data phase
    always @(posedge HCLK) begin
        cycles++;
        if (HREADY) begin
            dataCheck  = addrCheck;
            dataExpect = addrExpect;
            dataName   = addrName;
        end
    end

    always @(negedge HCLK) begin
        if (dataCheck && HREADY) begin
            checks++;
            if (HRDATA !== dataExpect) begin
                errors++;
                $display("[ERROR] %s expected %h actual %h", dataName, dataExpect, HRDATA);
            end
            dataCheck = 1'b0;
        end
    end

    initial begin
        logic [31:0] addrList [40];
        logic [31:0] rnd;
        logic [31:0] base;
        logic [31:0] value;
        logic [31:0] first;
        logic [31:0] second;
        int          startCycle;
        int          waited;
        seed   = 32'h705d1d83;
        reset  = 1'b1;
        HADDR  = '0;
        HTRANS = IDLE;
        HSIZE  = WORD;
        HWRITE = 1'b0;
        HWDATA = '0;
        gpioIn = '0;
        gpioOutModel = '0;
        gpioOeModel  = '0;
        gpioInModel  = '0;
        repeat (16) @(posedge HCLK);
        #1;
        reset = 1'b0;

        checkValue("reset gpioOut", 32'h0, gpioOut);
        checkValue("reset gpioOe", 32'h0, gpioOe);
        checkValue("reset timerFlag", 32'h0, timerFlag);
        readCheck({4'h8, 28'h0}, "unmapped read");
        @(negedge HCLK);
        checkValue("unmapped HREADY", 32'h1, HREADY);
        @(posedge HCLK);
        #1;

        // back-to-back word traffic with wrapping offsets
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            addrList[i] = {`RAM_SLOT, rnd[27:2], 2'b00};
            writeBus(addrList[i], WORD, $random(seed));
        end
        for (int i = 0; i < 40; i++) begin
            readCheck(addrList[i], $sformatf("ram word %0d", i));
        end
        base = {`RAM_SLOT, 28'h0};
        writeBus(base + (`RAM_WORDS * 4) + 8, WORD, $random(seed));
        readCheck(base + 8, "ram wrap");

        base = {`RAM_SLOT, 28'h40};
        writeBus(base, WORD, $random(seed));
        for (int lane = 0; lane < 4; lane++) begin
            writeBus(base + lane, BYTE, $random(seed));
            readCheck(base, $sformatf("byte lane %0d", lane));
        end
        for (int half = 0; half < 2; half++) begin
            writeBus(base + 2 * half, HALF, $random(seed));
            readCheck(base, $sformatf("half lane %0d", half));
        end
        idleCycle();

        writeBus(regAddr(`GPIO_SLOT, GPIO_OUT), WORD, $random(seed));
        idleCycle();
        checkValue("gpioOut pins", gpioOutModel, gpioOut);
        writeBus(regAddr(`GPIO_SLOT, GPIO_OE), WORD, $random(seed));
        idleCycle();
        checkValue("gpioOe pins", gpioOeModel, gpioOe);
        readCheck(regAddr(`GPIO_SLOT, GPIO_OUT), "gpio out read");
        readCheck(regAddr(`GPIO_SLOT, GPIO_OE), "gpio oe read");
        gpioIn      = $random(seed);
        gpioInModel = gpioIn;
        repeat (3) idleCycle();
        readCheck(regAddr(`GPIO_SLOT, GPIO_IN), "gpio in read");
        // input register is read only
        writeBus(regAddr(`GPIO_SLOT, GPIO_IN), WORD, $random(seed));
        readCheck(regAddr(`GPIO_SLOT, GPIO_IN), "gpio in after write");
        idleCycle();
        checkValue("gpioOut after in write", gpioOutModel, gpioOut);
        checkValue("gpioOe after in write", gpioOeModel, gpioOe);

        writeBus(regAddr(`TIMER_SLOT, TMR_LOAD), WORD, 32'd20);
        writeBus(regAddr(`TIMER_SLOT, TMR_CTRL), WORD, 32'd1);
        idleCycle();
        startCycle = cycles;
        waited = 0;
        while (!timerFlag && (waited < flagTimeout)) begin
            @(posedge HCLK);
            #1;
            waited++;
        end
        checks++;
        if (!timerFlag) begin
            timeouts++;
            $display("timeout: timerFlag did not rise within %0d cycles", flagTimeout);
        end else if ((cycles - startCycle < 20) || (cycles - startCycle > 22)) begin
            errors++;
            $display("[ERROR] timer expiry expected 20 to 22 cycles actual %0d",
                     cycles - startCycle);
        end
        readValue(regAddr(`TIMER_SLOT, TMR_COUNT), value);
        checks++;
        if (value > 32'd20) begin
            errors++;
            $display("[ERROR] timer count expected at most 20 actual %0d", value);
        end
        writeBus(regAddr(`TIMER_SLOT, TMR_STATUS), WORD, 32'h0);
        idleCycle();
        checkValue("timerFlag after clear", 32'h0, timerFlag);
        writeBus(regAddr(`TIMER_SLOT, TMR_CTRL), WORD, 32'd0);
        idleCycle();
        readValue(regAddr(`TIMER_SLOT, TMR_COUNT), first);
        idleCycle();
        readValue(regAddr(`TIMER_SLOT, TMR_COUNT), second);
        checkValue("timer count hold", first, second);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/fabricPkg.sv
source/ahblSplitter.sv
source/ahblRam.sv
source/ahblGpio.sv
source/ahblTimer.sv
source/peripheralFabric.sv
verification/tbClock.sv
verification/peripheralFabricTb.sv

//--- Bender.yml
package:
  name: peripheral_fabric

sources:
  - include_dirs:
      - source
    files:
      - source/fabricPkg.sv
      - source/ahblSplitter.sv
      - source/ahblRam.sv
      - source/ahblGpio.sv
      - source/ahblTimer.sv
      - source/peripheralFabric.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/tbClock.sv
      - verification/peripheralFabricTb.sv
